// File: design/i2c_settings.svh
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

////////////////////
// Bus timing
////////////////////

// Half of one SCL bit slot, in clk1 cycles
`define I2C_HALF_DIV 4

// Cycles each display digit stays lit
`define SEG_SCAN_DIV 16

////////////////////
// Register map, byte offsets
////////////////////

`define REG_CMD0   4'h0
`define REG_CMD1   4'h4
`define REG_STATUS 4'h8
`define REG_RDATA  4'hC

`endif

// File: design/i2c_pkg.sv
package i2c_pkg;

	////////////////////
	// Command word
	////////////////////

	// Raw view for the AXI side, field view for the masters
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [14:0] pad_hi;
			logic        rw;
			logic        pad_lo;
			logic [6:0]  addr;
			logic [7:0]  wdata;
		} f;
	} cmd_word_t;

	////////////////////
	// Frame sequence
	////////////////////

	// One slot per state, except address and data which loop over bits
	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_START = 3'd1,
		ST_ADDR  = 3'd2,
		ST_RW    = 3'd3,
		ST_ACK1  = 3'd4,
		ST_DATA  = 3'd5,
		ST_ACK2  = 3'd6,
		ST_STOP  = 3'd7
	} frame_state_t;

	// One hex digit of the display
	typedef logic [3:0] hex_digit_t;

endpackage

// File: design/axil_cmd_regs.sv
`timescale 1ns/10ps
`include "i2c_settings.svh"

module axil_cmd_regs (
	input  logic               clk1,
	input  logic               reset,
	input  logic [3:0]         awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  logic [31:0]        wdata,
	input  logic [3:0]         wstrb,
	input  logic               wvalid,
	output logic               wready,
	output logic [1:0]         bresp,
	output logic               bvalid,
	input  logic               bready,
	input  logic [3:0]         araddr,
	input  logic               arvalid,
	output logic               arready,
	output logic [31:0]        rdata,
	output logic [1:0]         rresp,
	output logic               rvalid,
	input  logic               rready,
	output logic               start0,
	output logic               start1,
	output i2c_pkg::cmd_word_t cmd0,
	output i2c_pkg::cmd_word_t cmd1,
	input  logic               busy0,
	input  logic               busy1,
	input  logic               done0,
	input  logic               done1,
	input  logic               nack0,
	input  logic               nack1,
	input  logic [7:0]         rdata0,
	input  logic [7:0]         rdata1
);

	logic        wr_fire;
	logic        rd_fire;
	logic        done0_seen;
	logic        done1_seen;
	logic [31:0] status_word;

	assign wr_fire = awvalid & awready & wvalid & wready;
	assign rd_fire = arvalid & arready;

	// Always OKAY
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	assign status_word = {26'd0, nack1, nack0, done1_seen, done0_seen, busy1, busy0};

	////////////////////
	// Write channel
	////////////////////

	always_ff @(posedge clk1) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			start0 <= 1'b0;
			start1 <= 1'b0;
		end else begin
			awready <= 1'b0;
			wready <= 1'b0;
			start0 <= 1'b0;
			start1 <= 1'b0;
			// One write in flight at a time
			if (awvalid && wvalid && !bvalid && !awready) begin
				awready <= 1'b1;
				wready <= 1'b1;
			end
			if (wr_fire) begin
				bvalid <= 1'b1;
				start0 <= (awaddr == `REG_CMD0);
				start1 <= (awaddr == `REG_CMD1);
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Command words, byte lanes per wstrb
	always_ff @(posedge clk1) begin
		if (wr_fire) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i] && awaddr == `REG_CMD0)
					cmd0.raw[8*i +: 8] <= wdata[8*i +: 8];
				if (wstrb[i] && awaddr == `REG_CMD1)
					cmd1.raw[8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	// Sticky done flags, a new pulse wins over the clear
	always_ff @(posedge clk1) begin
		if (reset) begin
			done0_seen <= 1'b0;
			done1_seen <= 1'b0;
		end else begin
			if (done0)
				done0_seen <= 1'b1;
			else if (rd_fire && araddr == `REG_STATUS)
				done0_seen <= 1'b0;
			if (done1)
				done1_seen <= 1'b1;
			else if (rd_fire && araddr == `REG_STATUS)
				done1_seen <= 1'b0;
		end
	end

	////////////////////
	// Read channel
	////////////////////

	always_ff @(posedge clk1) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid && !rvalid && !arready;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk1) begin
		if (rd_fire) begin
			case (araddr)
				`REG_CMD0:   rdata <= cmd0.raw;
				`REG_CMD1:   rdata <= cmd1.raw;
				`REG_STATUS: rdata <= status_word;
				`REG_RDATA:  rdata <= {16'd0, rdata1, rdata0};
				default:     rdata <= 32'd0;
			endcase
		end
	end

endmodule

// File: design/i2c_frame_master.sv
`timescale 1ns/10ps
`include "i2c_settings.svh"

module i2c_frame_master (
	input  logic               clk1,
	input  logic               reset,
	input  logic               start,
	input  logic               grant,
	input  i2c_pkg::cmd_word_t cmd,
	output logic               req,
	output logic               busy,
	output logic               done,
	output logic               nack,
	output logic [7:0]         rdata,
	output logic [7:0]         frame_data,
	output logic [6:0]         frame_addr,
	output logic               scl,
	output logic               sda_out,
	output logic               sda_oe,
	input  logic               sda_in
);
	import i2c_pkg::*;

	localparam int SLOT = 2 * `I2C_HALF_DIV;
	localparam int PW = $clog2(SLOT);
	localparam logic [PW-1:0] LAST_PH = PW'(SLOT - 1);
	localparam logic [PW-1:0] HIGH_PH = PW'(`I2C_HALF_DIV);
	localparam logic [PW-1:0] SAMPLE_PH = PW'(`I2C_HALF_DIV + `I2C_HALF_DIV / 2);

	frame_state_t  state;
	logic [PW-1:0] phase;
	logic [2:0]    bit_cnt;
	logic          take_cmd;
	logic          slot_end;
	logic          scl_high;
	logic          sample;
	logic [6:0]    addr_q;
	logic          rw_q;
	logic [7:0]    wdata_q;
	logic [7:0]    tx;
	logic [7:0]    rx;

	assign take_cmd = start & ~req;
	assign slot_end = (phase == LAST_PH);
	assign scl_high = (phase >= HIGH_PH);
	assign sample = (phase == SAMPLE_PH);

	assign busy = req | (state != ST_IDLE);
	assign rdata = rx;
	assign frame_addr = addr_q;
	assign frame_data = rw_q ? rx : wdata_q;

	////////////////////
	// Frame sequencer
	////////////////////

	always_ff @(posedge clk1) begin
		if (reset) begin
			state <= ST_IDLE;
			phase <= '0;
			bit_cnt <= 3'd0;
			req <= 1'b0;
			done <= 1'b0;
			nack <= 1'b0;
		end else begin
			done <= 1'b0;
			if (take_cmd) begin
				req <= 1'b1;
				nack <= 1'b0;
			end
			if (state == ST_IDLE) begin
				// Waits here until the arbiter hands over the bus
				phase <= '0;
				if (req && grant)
					state <= ST_START;
			end else begin
				phase <= slot_end ? '0 : phase + 1'b1;
				if (sample && sda_in && (state == ST_ACK1 || state == ST_ACK2))
					nack <= 1'b1;
				if (slot_end) begin
					case (state)
						ST_START: begin
							state <= ST_ADDR;
							bit_cnt <= 3'd6;
						end
						ST_ADDR: begin
							if (bit_cnt == 3'd0)
								state <= ST_RW;
							else
								bit_cnt <= bit_cnt - 1'b1;
						end
						ST_RW: state <= ST_ACK1;
						ST_ACK1: begin
							state <= ST_DATA;
							bit_cnt <= 3'd7;
						end
						ST_DATA: begin
							if (bit_cnt == 3'd0)
								state <= ST_ACK2;
							else
								bit_cnt <= bit_cnt - 1'b1;
						end
						ST_ACK2: state <= ST_STOP;
						default: begin
							// End of stop slot, SDA is released with SCL high
							state <= ST_IDLE;
							req <= 1'b0;
							done <= 1'b1;
						end
					endcase
				end
			end
		end
	end

	// Command copy and shift registers
	always_ff @(posedge clk1) begin
		if (take_cmd) begin
			addr_q <= cmd.f.addr;
			rw_q <= cmd.f.rw;
			wdata_q <= cmd.f.wdata;
			tx <= {cmd.f.addr, cmd.f.rw};
		end else if (slot_end) begin
			if (state == ST_ADDR || state == ST_RW || state == ST_DATA)
				tx <= {tx[6:0], 1'b0};
			else if (state == ST_ACK1)
				tx <= wdata_q;
		end
		if (sample && state == ST_DATA && rw_q)
			rx <= {rx[6:0], sda_in};
	end

	////////////////////
	// Bus lines
	////////////////////

	always_comb begin
		scl = scl_high;
		sda_out = 1'b1;
		sda_oe = 1'b0;
		case (state)
			ST_IDLE: scl = 1'b1;
			ST_START: begin
				// SDA falls halfway through with SCL held high
				scl = 1'b1;
				sda_out = 1'b0;
				sda_oe = scl_high;
			end
			ST_ADDR, ST_RW: begin
				sda_out = tx[7];
				sda_oe = 1'b1;
			end
			ST_DATA: begin
				sda_out = tx[7];
				sda_oe = ~rw_q;
			end
			ST_STOP: begin
				sda_out = 1'b0;
				sda_oe = 1'b1;
			end
			default: sda_oe = 1'b0;
		endcase
	end

endmodule

// File: design/i2c_bus_arbiter.sv
`timescale 1ns/10ps

module i2c_bus_arbiter (
	input  logic       clk1,
	input  logic       reset,
	input  logic       arb_select,
	input  logic       req0,
	input  logic       req1,
	input  logic       scl0,
	input  logic       scl1,
	input  logic       sda_out0,
	input  logic       sda_out1,
	input  logic       sda_oe0,
	input  logic       sda_oe1,
	input  logic       done0,
	input  logic       done1,
	input  logic [6:0] frame_addr0,
	input  logic [6:0] frame_addr1,
	input  logic [7:0] frame_data0,
	input  logic [7:0] frame_data1,
	output logic       grant0,
	output logic       grant1,
	output logic       scl,
	output logic       sda_out,
	output logic       sda_oe,
	output logic [6:0] shown_addr,
	output logic [7:0] shown_data
);
	import i2c_pkg::*;

	logic       busy_bus;
	hex_digit_t data_hi;
	hex_digit_t data_lo;

	// Bus stays owned while the granted master keeps req up
	assign busy_bus = (grant0 & req0) | (grant1 & req1);

	////////////////////
	// Grant
	////////////////////

	always_ff @(posedge clk1) begin
		if (reset) begin
			grant0 <= 1'b0;
			grant1 <= 1'b0;
		end else if (!busy_bus) begin
			if (req0 && req1) begin
				grant0 <= ~arb_select;
				grant1 <= arb_select;
			end else begin
				grant0 <= req0;
				grant1 <= req1;
			end
		end
	end

	// Idle bus keeps SCL high and SDA released
	always_comb begin
		if (grant0) begin
			scl = scl0;
			sda_out = sda_out0;
			sda_oe = sda_oe0;
		end else if (grant1) begin
			scl = scl1;
			sda_out = sda_out1;
			sda_oe = sda_oe1;
		end else begin
			scl = 1'b1;
			sda_out = 1'b1;
			sda_oe = 1'b0;
		end
	end

	////////////////////
	// Last frame
	////////////////////

	always_ff @(posedge clk1) begin
		if (reset) begin
			shown_addr <= 7'd0;
			data_hi <= 4'h0;
			data_lo <= 4'h0;
		end else if (done0) begin
			shown_addr <= frame_addr0;
			data_hi <= frame_data0[7:4];
			data_lo <= frame_data0[3:0];
		end else if (done1) begin
			shown_addr <= frame_addr1;
			data_hi <= frame_data1[7:4];
			data_lo <= frame_data1[3:0];
		end
	end

	assign shown_data = {data_hi, data_lo};

endmodule

// File: design/seg_hex_scan.sv
`timescale 1ns/10ps
`include "i2c_settings.svh"

module seg_hex_scan (
	input  logic       clk1,
	input  logic       reset,
	input  logic [6:0] shown_addr,
	input  logic [7:0] shown_data,
	output logic [3:0] anode,
	output logic [6:0] cathode
);
	import i2c_pkg::*;

	localparam int SW = $clog2(`SEG_SCAN_DIV);
	localparam logic [SW-1:0] SCAN_LAST = SW'(`SEG_SCAN_DIV - 1);

	logic [SW-1:0] div;
	logic [1:0]    sel;
	hex_digit_t    digit;

	// Active-low pattern, segment a in bit 6
	function automatic logic [6:0] seg_decode(input hex_digit_t d);
		case (d)
			4'h0: return 7'b0000001;
			4'h1: return 7'b1001111;
			4'h2: return 7'b0010010;
			4'h3: return 7'b0000110;
			4'h4: return 7'b1001100;
			4'h5: return 7'b0100100;
			4'h6: return 7'b0100000;
			4'h7: return 7'b0001111;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0000100;
			4'hA: return 7'b0001000;
			4'hB: return 7'b1100000;
			4'hC: return 7'b0110001;
			4'hD: return 7'b1000010;
			4'hE: return 7'b0110000;
			default: return 7'b0111000;
		endcase
	endfunction

	// Leftmost digit first
	always_comb begin
		case (sel)
			2'd0: digit = {1'b0, shown_addr[6:4]};
			2'd1: digit = shown_addr[3:0];
			2'd2: digit = shown_data[7:4];
			default: digit = shown_data[3:0];
		endcase
	end

	always_ff @(posedge clk1) begin
		if (reset) begin
			div <= '0;
			sel <= 2'd0;
			anode <= 4'b1111;
			cathode <= 7'b1111111;
		end else if (div == SCAN_LAST) begin
			div <= '0;
			sel <= sel + 1'b1;
			anode <= ~(4'b0001 << sel);
			cathode <= seg_decode(digit);
		end else begin
			div <= div + 1'b1;
		end
	end

endmodule

// File: design/dual_i2c_top.sv
`timescale 1ns/10ps

module dual_i2c_top (
	input  logic        clk1,
	input  logic        reset,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output logic        scl,
	output logic        sda_out,
	output logic        sda_oe,
	input  logic        sda_in,
	input  logic        arb_select,
	output logic [3:0]  anode,
	output logic [6:0]  cathode
);
	import i2c_pkg::*;

	cmd_word_t  cmd0;
	cmd_word_t  cmd1;
	logic       start0;
	logic       start1;
	logic       req0;
	logic       req1;
	logic       grant0;
	logic       grant1;
	logic       busy0;
	logic       busy1;
	logic       done0;
	logic       done1;
	logic       nack0;
	logic       nack1;
	logic [7:0] rdata0;
	logic [7:0] rdata1;
	logic [7:0] frame_data0;
	logic [7:0] frame_data1;
	logic [6:0] frame_addr0;
	logic [6:0] frame_addr1;
	logic       scl0;
	logic       scl1;
	logic       sda_out0;
	logic       sda_out1;
	logic       sda_oe0;
	logic       sda_oe1;
	logic [6:0] shown_addr;
	logic [7:0] shown_data;

	axil_cmd_regs u_regs (
		.clk1(clk1), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.start0(start0), .start1(start1), .cmd0(cmd0), .cmd1(cmd1),
		.busy0(busy0), .busy1(busy1), .done0(done0), .done1(done1),
		.nack0(nack0), .nack1(nack1), .rdata0(rdata0), .rdata1(rdata1)
	);

	// Master 0
	i2c_frame_master u_master0 (
		.clk1(clk1), .reset(reset), .start(start0), .grant(grant0), .cmd(cmd0),
		.req(req0), .busy(busy0), .done(done0), .nack(nack0), .rdata(rdata0),
		.frame_data(frame_data0), .frame_addr(frame_addr0),
		.scl(scl0), .sda_out(sda_out0), .sda_oe(sda_oe0), .sda_in(sda_in)
	);

	// Master 1
	i2c_frame_master u_master1 (
		.clk1(clk1), .reset(reset), .start(start1), .grant(grant1), .cmd(cmd1),
		.req(req1), .busy(busy1), .done(done1), .nack(nack1), .rdata(rdata1),
		.frame_data(frame_data1), .frame_addr(frame_addr1),
		.scl(scl1), .sda_out(sda_out1), .sda_oe(sda_oe1), .sda_in(sda_in)
	);

	i2c_bus_arbiter u_arbiter (
		.clk1(clk1), .reset(reset), .arb_select(arb_select),
		.req0(req0), .req1(req1), .scl0(scl0), .scl1(scl1),
		.sda_out0(sda_out0), .sda_out1(sda_out1), .sda_oe0(sda_oe0), .sda_oe1(sda_oe1),
		.done0(done0), .done1(done1),
		.frame_addr0(frame_addr0), .frame_addr1(frame_addr1),
		.frame_data0(frame_data0), .frame_data1(frame_data1),
		.grant0(grant0), .grant1(grant1),
		.scl(scl), .sda_out(sda_out), .sda_oe(sda_oe),
		.shown_addr(shown_addr), .shown_data(shown_data)
	);

	seg_hex_scan u_display (
		.clk1(clk1), .reset(reset),
		.shown_addr(shown_addr), .shown_data(shown_data),
		.anode(anode), .cathode(cathode)
	);

endmodule

// File: sim/tb_dual_i2c.sv
`timescale 1ns/10ps
`include "i2c_settings.svh"

module tb_dual_i2c;
	import i2c_pkg::*;

	logic        clk1;
	logic        reset;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        scl;
	logic        sda_out;
	logic        sda_oe;
	logic        sda_in;
	logic        arb_select;
	logic [3:0]  anode;
	logic [6:0]  cathode;

	logic [7:0]  cases [0:127];
	int          errors;
	int          failed_tests;
	logic        slave_nack;
	logic [7:0]  slave_rd;
	logic [15:0] frames [$];

	dual_i2c_top DUT (.*);

	initial begin
		clk1 = 1'b0;
		forever #4 clk1 = ~clk1;
	end

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input logic [6:0] got, input logic [6:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// Segments a to g that each digit lights, active high
	task automatic check_seg(input string name, input hex_digit_t d, input logic [6:0] got);
		logic [6:0] lit;
		logic [6:0] exp;
		case (d)
			4'h0: lit = 7'b1111110;
			4'h1: lit = 7'b0110000;
			4'h2: lit = 7'b1101101;
			4'h3: lit = 7'b1111001;
			4'h4: lit = 7'b0110011;
			4'h5: lit = 7'b1011011;
			4'h6: lit = 7'b1011111;
			4'h7: lit = 7'b1110000;
			4'h8: lit = 7'b1111111;
			4'h9: lit = 7'b1111011;
			4'hA: lit = 7'b1110111;
			4'hB: lit = 7'b0011111;
			4'hC: lit = 7'b1001110;
			4'hD: lit = 7'b0111101;
			4'hE: lit = 7'b1001111;
			default: lit = 7'b1000111;
		endcase
		// Cathode pins are active low
		exp = ~lit;
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	////////////////////
	// AXI4-Lite driver
	////////////////////

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk1);
		awaddr <= addr;
		wdata <= data;
		wstrb <= 4'hF;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		bready <= 1'b1;
		do @(posedge clk1); while (!awready);
		check_bit("wready", wready, 1'b1);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		do @(posedge clk1); while (!bvalid);
		bready <= 1'b0;
		check_byte("bresp", {6'd0, bresp}, 8'h00);
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
		@(posedge clk1);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b1;
		do @(posedge clk1); while (!arready);
		arvalid <= 1'b0;
		do @(posedge clk1); while (!rvalid);
		rready <= 1'b0;
		data = rdata;
		check_byte("rresp", {6'd0, rresp}, 8'h00);
	endtask

	////////////////////
	// I2C slave model
	////////////////////

	logic scl_q;
	logic line_q;
	logic in_frame;
	int   rise_cnt;
	logic [6:0] s_addr;
	logic s_rw;
	logic [7:0] s_data;
	wire  line = sda_oe ? sda_out : sda_in;

	always @(posedge clk1) begin
		if (reset) begin
			scl_q <= 1'b1;
			line_q <= 1'b1;
			in_frame <= 1'b0;
			rise_cnt <= 0;
			sda_in <= 1'b1;
		end else begin
			scl_q <= scl;
			line_q <= line;
			if (scl && scl_q && line_q && !line) begin
				// Start condition
				if (in_frame) begin
					$display("Error at %0t: a new frame started inside another frame", $time);
					errors++;
				end
				in_frame <= 1'b1;
				rise_cnt <= 0;
			end else if (scl && scl_q && !line_q && line && in_frame) begin
				in_frame <= 1'b0;
				frames.push_back({s_addr, s_rw, s_data});
			end else if (in_frame && scl && !scl_q) begin
				rise_cnt <= rise_cnt + 1;
				// Acknowledge and read data slots belong to the slave
				if (sda_oe && (rise_cnt == 8 || rise_cnt == 17 ||
						(s_rw && rise_cnt >= 9 && rise_cnt <= 16))) begin
					$display("Error at %0t: the master drove SDA in a slot of the slave", $time);
					errors++;
				end
				if (rise_cnt < 7)
					s_addr <= {s_addr[5:0], line};
				else if (rise_cnt == 7)
					s_rw <= line;
				else if (rise_cnt >= 9 && rise_cnt <= 16)
					s_data <= {s_data[6:0], line};
			end else if (in_frame && !scl && scl_q) begin
				// Next slot index equals rising edges seen so far
				if (rise_cnt == 8)
					sda_in <= slave_nack;
				else if (rise_cnt >= 9 && rise_cnt <= 16 && s_rw)
					sda_in <= slave_rd[16 - rise_cnt];
				else if (rise_cnt == 17)
					sda_in <= 1'b0;
				else
					sda_in <= 1'b1;
			end
		end
	end

	// Records one pattern per new anode step
	task automatic collect_display(input logic [6:0] exp_addr, input logic [7:0] exp_data);
		logic [6:0] pat [0:3];
		logic [3:0] seen;
		logic [3:0] prev;
		int n;
		seen = 4'b0000;
		prev = anode;
		n = 0;
		while (seen != 4'b1111 && n < 200) begin
			@(posedge clk1);
			if (anode != prev) begin
				case (anode)
					4'b1110: begin
						pat[0] = cathode;
						seen[0] = 1'b1;
					end
					4'b1101: begin
						pat[1] = cathode;
						seen[1] = 1'b1;
					end
					4'b1011: begin
						pat[2] = cathode;
						seen[2] = 1'b1;
					end
					4'b0111: begin
						pat[3] = cathode;
						seen[3] = 1'b1;
					end
					default: ;
				endcase
			end
			prev = anode;
			n++;
		end
		if (seen != 4'b1111) begin
			$display("Error at %0t: the display never scanned all four digits", $time);
			errors++;
		end else begin
			check_seg("cathode digit 0", {1'b0, exp_addr[6:4]}, pat[0]);
			check_seg("cathode digit 1", exp_addr[3:0], pat[1]);
			check_seg("cathode digit 2", exp_data[7:4], pat[2]);
			check_seg("cathode digit 3", exp_data[3:0], pat[3]);
		end
	endtask

	////////////////////
	// One test from the case file
	////////////////////

	task automatic run_case(input int t);
		int base;
		int polls;
		logic [7:0] mode;
		logic [7:0] rw;
		logic [6:0] addr_a;
		logic [6:0] addr_b;
		logic [7:0] data_a;
		logic [7:0] data_b;
		logic [3:0] done_mask;
		logic [31:0] st;
		logic [31:0] acc;
		logic [15:0] fr;
		int err_before;
		base = 1 + t * 10;
		mode = cases[base];
		rw = cases[base + 1];
		addr_a = cases[base + 2][6:0];
		data_a = cases[base + 3];
		addr_b = cases[base + 6][6:0];
		data_b = cases[base + 7];
		err_before = errors;
		frames.delete();
		slave_nack = cases[base + 4][0];
		slave_rd = data_a;
		arb_select <= cases[base + 5][0];
		done_mask = (mode == 8'd0) ? 4'b0100 : (mode == 8'd1) ? 4'b1000 : 4'b1100;
		if (mode == 8'd2) begin
			// Selected master first and the other right behind it
			if (cases[base + 5][0]) begin
				axi_write(`REG_CMD1, {15'd0, rw[0], 1'b0, addr_b, data_b});
				axi_write(`REG_CMD0, {15'd0, rw[0], 1'b0, addr_a, data_a});
			end else begin
				axi_write(`REG_CMD0, {15'd0, rw[0], 1'b0, addr_a, data_a});
				axi_write(`REG_CMD1, {15'd0, rw[0], 1'b0, addr_b, data_b});
			end
		end else begin
			axi_write(mode == 8'd0 ? `REG_CMD0 : `REG_CMD1,
				{15'd0, rw[0], 1'b0, addr_a, data_a});
		end
		acc = 32'd0;
		polls = 0;
		do begin
			axi_read(`REG_STATUS, st);
			acc = acc | st;
			polls++;
		end while ((acc[3:0] & done_mask) != done_mask && polls < 200);
		if ((acc[3:0] & done_mask) != done_mask) begin
			$display("Error at %0t: test %0d frame never reported done", $time, t);
			errors++;
		end
		if (mode != 8'd1) begin
			check_bit("busy0 during frame", acc[0], 1'b1);
			check_bit("nack0", st[4], cases[base + 4][0]);
		end
		if (mode != 8'd0) begin
			check_bit("busy1 during frame", acc[1], 1'b1);
			check_bit("nack1", st[5], cases[base + 4][0]);
		end
		axi_read(`REG_STATUS, st);
		check_bit("done0 after clear", st[2], 1'b0);
		check_bit("done1 after clear", st[3], 1'b0);
		check_bit("busy0 after frame", st[0], 1'b0);
		check_bit("busy1 after frame", st[1], 1'b0);
		if (mode != 8'd2 && rw[0]) begin
			axi_read(`REG_RDATA, st);
			check_byte(mode == 8'd0 ? "rdata0" : "rdata1",
				mode == 8'd0 ? st[7:0] : st[15:8], data_a);
		end
		// Frames as the slave saw them
		if (frames.size() != ((mode == 8'd2) ? 2 : 1)) begin
			$display("Error at %0t: slave saw %0d frames", $time, frames.size());
			errors++;
		end else begin
			fr = frames[0];
			if (mode == 8'd2 && cases[base + 5][0])
				check_addr("first frame address", fr[15:9], addr_b);
			else
				check_addr("first frame address", fr[15:9], addr_a);
			check_bit("first frame rw", fr[8], rw[0]);
			if (!rw[0])
				check_byte("first frame data", fr[7:0],
					(mode == 8'd2 && cases[base + 5][0]) ? data_b : data_a);
			if (mode == 8'd2) begin
				fr = frames[1];
				check_addr("second frame address", fr[15:9],
					cases[base + 5][0] ? addr_a : addr_b);
				check_bit("second frame rw", fr[8], rw[0]);
				if (!rw[0])
					check_byte("second frame data", fr[7:0],
						cases[base + 5][0] ? data_a : data_b);
			end
		end
		collect_display(cases[base + 8][6:0], cases[base + 9]);
		if (errors != err_before) begin
			failed_tests++;
			$display("test %0d mode %0d: failed", t, mode);
		end else begin
			$display("test %0d mode %0d: passed", t, mode);
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		logic [31:0] st;
		reset = 1'b1;
		awaddr = 4'h0;
		awvalid = 1'b0;
		wdata = 32'd0;
		wstrb = 4'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = 4'h0;
		arvalid = 1'b0;
		rready = 1'b0;
		sda_in = 1'b1;
		arb_select = 1'b0;
		slave_nack = 1'b0;
		slave_rd = 8'h00;
		errors = 0;
		failed_tests = 0;
		$readmemh("sim/i2c_cases.txt", cases);
		repeat (4) @(posedge clk1);
		reset <= 1'b0;
		@(posedge clk1);
		check_bit("scl after reset", scl, 1'b1);
		check_byte("anode after reset", {4'h0, anode}, 8'h0F);
		axi_read(`REG_STATUS, st);
		check_byte("status after reset", st[7:0], 8'h00);
		for (int t = 0; t < int'(cases[0]); t++)
			run_case(t);
		$display("Tests run %0d, tests failed %0d, errors %0d", cases[0], failed_tests, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog of 400 cycles per test plus setup margin
	initial begin
		int limit;
		#1;
		limit = int'(cases[0]) * 400 + 1000;
		repeat (limit) @(posedge clk1);
		$display("Timeout: the run did not finish, master states %s and %s",
			DUT.u_master0.state.name(), DUT.u_master1.state.name());
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: sim/i2c_cases.txt
// First value: number of tests. Then ten fields per test:
// mode(0 m0, 1 m1, 2 both) rw addr data nack arb_select addr_b data_b last_addr last_data
07
00 00 50 A5 00 00 00 00 50 A5
01 01 3C 96 00 00 00 00 3C 96
00 00 22 5A 01 00 00 00 22 5A
02 00 11 C3 00 00 6E 3D 6E 3D
02 00 48 7E 00 01 2B E1 48 7E
00 01 7F 0F 00 01 00 00 7F 0F
01 00 05 B4 00 00 00 00 05 B4

// File: flist.f
+incdir+design
design/i2c_pkg.sv
design/axil_cmd_regs.sv
design/i2c_frame_master.sv
design/i2c_bus_arbiter.sv
design/seg_hex_scan.sv
design/dual_i2c_top.sv
sim/tb_dual_i2c.sv

// File: run_sim.sh
#!/bin/bash
# Builds and runs the testbench with Verilator from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_dual_i2c -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
exit 0
